/* accel_host_top.sv */
`timescale 1ns/1ps
`default_nettype none

module accel_host_top import accel_pkg::*; #(
	parameter int FIFO_DEPTH = 64,
	parameter int BLOCK_SIZE = 8,
	parameter int BUFFER_HEADROOM = 4,
	parameter int CNT_W = $clog2(FIFO_DEPTH) + 1
) (
	input  logic       okClk,
	input  logic       rst,
	input  ctrl_t      ctrl,
	input  logic       pipe_in_write,
	input  word_t      pipe_in_data,
	output logic       pipe_in_ready,
	input  logic       pipe_out_read,
	output word_t      pipe_out_data,
	output logic       pipe_out_empty,
	output logic       pipe_out_ready,
	input  logic       data_rd,
	output feat_pair_t data_out,
	output logic       data_empty,
	output op_status_t status,
	output logic       irq
);

	// ----------------------------------------------------------------------
	// internal nets
	// ----------------------------------------------------------------------
	logic             src_rd;
	word_t            src_data;
	logic             src_empty;
	logic [CNT_W-1:0] in_count;
	logic [CNT_W-1:0] out_count;
	logic [CNT_W-1:0] data_count;
	logic [CNT_W-1:0] dest_count;
	logic             mv_we;
	word_t            mv_data;
	logic             out_we;
	word_t            out_data;
	logic             cmd_we;
	cmd_t             cmd;
	logic             data_we;
	feat_pair_t       data_word;

	sync_fifo #(.payload_t(word_t), .FIFO_DEPTH(FIFO_DEPTH), .CNT_W(CNT_W)) pipe_in_fifo_i (
		.okClk (okClk),
		.rst   (rst),
		.clear (ctrl.pipe_clear),
		.wr    (pipe_in_write),   // host side
		.din   (pipe_in_data),
		.rd    (src_rd),
		.dout  (src_data),
		.empty (src_empty),
		.full  (),
		.count (in_count));

	pipe_throttle #(
		.FIFO_DEPTH      (FIFO_DEPTH),
		.BLOCK_SIZE      (BLOCK_SIZE),
		.BUFFER_HEADROOM (BUFFER_HEADROOM),
		.CNT_W           (CNT_W)
	) throttle_i (
		.okClk          (okClk),
		.rst            (rst),
		.in_count       (in_count),
		.out_count      (out_count),
		.pipe_in_ready  (pipe_in_ready),
		.pipe_out_ready (pipe_out_ready));

	stream_mover #(.FIFO_DEPTH(FIFO_DEPTH), .CNT_W(CNT_W)) mover_i (
		.okClk      (okClk),
		.rst        (rst),
		.move_en    (ctrl.move_en),
		.src_data   (src_data),
		.src_empty  (src_empty),
		.dest_count (dest_count),
		.src_rd     (src_rd),
		.mv_we      (mv_we),
		.mv_data    (mv_data));

	dest_router #(.CNT_W(CNT_W)) router_i (
		.op_en      (ctrl.op_en),
		.op_run     (status.op_run),
		.mv_we      (mv_we),
		.mv_data    (mv_data),
		.out_count  (out_count),
		.data_count (data_count),
		.dest_count (dest_count),
		.out_we     (out_we),
		.out_data   (out_data),
		.cmd_we     (cmd_we),
		.cmd        (cmd),
		.data_we    (data_we),
		.data_word  (data_word));

	sync_fifo #(.payload_t(word_t), .FIFO_DEPTH(FIFO_DEPTH), .CNT_W(CNT_W)) pipe_out_fifo_i (
		.okClk (okClk),
		.rst   (rst),
		.clear (ctrl.pipe_clear),
		.wr    (out_we),
		.din   (out_data),
		.rd    (pipe_out_read),  // host side
		.dout  (pipe_out_data),
		.empty (pipe_out_empty),
		.full  (),
		.count (out_count));

	sync_fifo #(.payload_t(feat_pair_t), .FIFO_DEPTH(FIFO_DEPTH), .CNT_W(CNT_W)) data_fifo_i (
		.okClk (okClk),
		.rst   (rst),
		.clear (ctrl.csb_clear),
		.wr    (data_we),
		.din   (data_word),
		.rd    (data_rd),  // consumer read port
		.dout  (data_out),
		.empty (data_empty),
		.full  (),
		.count (data_count));

	csb csb_i (
		.okClk   (okClk),
		.rst     (rst),
		.clear   (ctrl.csb_clear),
		.op_en   (ctrl.op_en),
		.cmd_we  (cmd_we),
		.cmd     (cmd),
		.data_we (data_we),
		.status  (status),
		.irq     (irq));

endmodule

`default_nettype wire

/* accel_pkg.sv */
`default_nettype none

package accel_pkg;

	// ----------------------------------------------------------------------
	// widths and word types
	// ----------------------------------------------------------------------
	localparam int WORD_W = 32;  // host pipe word
	localparam int FEAT_W = 16;  // fixed-point feature

	typedef logic [WORD_W-1:0] word_t;

	typedef struct packed {
		logic [FEAT_W-1:0] hi;  // upper half of the host word
		logic [FEAT_W-1:0] lo;
	} feat_pair_t;

	typedef enum logic [2:0] {
		OP_CONV3X3 = 3'd0,
		OP_CONV1X1 = 3'd1,
		OP_MAXPOOL = 3'd2,
		OP_AVEPOOL = 3'd3
	} op_type_e;

	// ----------------------------------------------------------------------
	// command and control
	// ----------------------------------------------------------------------
	typedef struct packed {
		op_type_e    op_type;   // bits 31:29
		logic [12:0] reserved;
		logic [15:0] op_num;    // data words after the command
	} cmd_t;

	typedef struct packed {
		logic move_en;     // mover may drain pipe-in
		logic pipe_clear;  // flush pipe-in and pipe-out
		logic csb_clear;   // reset csb and data fifo
		logic op_en;       // accelerator path select
	} ctrl_t;

	typedef struct packed {
		logic        op_run;
		op_type_e    op_type;
		logic [15:0] op_num;
	} op_status_t;

	typedef enum logic [1:0] {
		DEST_PIPE_OUT = 2'd0,
		DEST_CMD      = 2'd1,
		DEST_DATA     = 2'd2
	} dest_e;

endpackage

`default_nettype wire

/* csb.sv */
`timescale 1ns/1ps
`default_nettype none

module csb import accel_pkg::*; (
	input  logic       okClk,
	input  logic       rst,
	input  logic       clear,
	input  logic       op_en,
	input  logic       cmd_we,
	input  cmd_t       cmd,
	input  logic       data_we,
	output op_status_t status,
	output logic       irq
);

	logic [15:0] data_cnt;  // data words seen in this op
	logic        cmd_take;
	logic        last_word;

	assign cmd_take  = cmd_we & op_en;
	assign last_word = data_we & status.op_run & ((data_cnt + 16'd1) == status.op_num);

	// ----------------------------------------------------------------------
	// run state
	// ----------------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (rst || clear) begin
			status.op_run  <= 1'b0;
			status.op_type <= OP_CONV3X3;
			status.op_num  <= '0;
			data_cnt       <= '0;
			irq            <= 1'b0;
		end else begin
			irq <= 1'b0;  // single-cycle pulse
			if (cmd_take) begin
				status.op_type <= cmd.op_type;
				status.op_num  <= cmd.op_num;
				data_cnt       <= '0;
				if (cmd.op_num == 16'd0) begin
					irq <= 1'b1;  // empty op finishes at once
				end else begin
					status.op_run <= 1'b1;
				end
			end else if (data_we && status.op_run) begin
				data_cnt <= data_cnt + 16'd1;
				if (last_word) begin
					status.op_run <= 1'b0;
					irq           <= 1'b1;
				end
			end
		end
	end

	// the router must steer by the current run state
	a_no_cmd_in_run: assert property (@(posedge okClk) disable iff (rst || clear)
		cmd_we |-> !status.op_run);
	a_no_data_idle: assert property (@(posedge okClk) disable iff (rst || clear)
		data_we |-> status.op_run);

endmodule

`default_nettype wire

/* dest_router.sv */
`timescale 1ns/1ps
`default_nettype none

module dest_router import accel_pkg::*; #(
	parameter int CNT_W = 7
) (
	input  logic             op_en,
	input  logic             op_run,
	input  logic             mv_we,
	input  word_t            mv_data,
	input  logic [CNT_W-1:0] out_count,
	input  logic [CNT_W-1:0] data_count,
	output logic [CNT_W-1:0] dest_count,
	output logic             out_we,
	output word_t            out_data,
	output logic             cmd_we,
	output cmd_t             cmd,
	output logic             data_we,
	output feat_pair_t       data_word
);

	dest_e dest;

	always_comb begin
		if (!op_en) begin
			dest = DEST_PIPE_OUT;  // host loopback
		end else if (!op_run) begin
			dest = DEST_CMD;       // idle so the next word is a command
		end else begin
			dest = DEST_DATA;
		end
	end

	// count back to the mover for the selected target
	always_comb begin
		case (dest)
			DEST_PIPE_OUT: dest_count = out_count;
			DEST_DATA:     dest_count = data_count;
			default:       dest_count = '0;  // csb always has room
		endcase
	end

	// ----------------------------------------------------------------------
	// strobes and payload views
	// ----------------------------------------------------------------------
	assign out_we  = mv_we & (dest == DEST_PIPE_OUT);
	assign cmd_we  = mv_we & (dest == DEST_CMD);
	assign data_we = mv_we & (dest == DEST_DATA);

	assign out_data  = mv_data;
	assign cmd       = cmd_t'(mv_data);
	assign data_word = feat_pair_t'(mv_data);  // hi from bits 31:16

endmodule

`default_nettype wire

/* pipe_throttle.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_throttle #(
	parameter int FIFO_DEPTH = 64,
	parameter int BLOCK_SIZE = 8,
	parameter int BUFFER_HEADROOM = 4,
	parameter int CNT_W = 7
) (
	input  logic             okClk,
	input  logic             rst,
	input  logic [CNT_W-1:0] in_count,
	input  logic [CNT_W-1:0] out_count,
	output logic             pipe_in_ready,
	output logic             pipe_out_ready
);

	// room for one more block minus slack for count latency
	localparam logic [CNT_W-1:0] IN_LIMIT  = CNT_W'(FIFO_DEPTH - BUFFER_HEADROOM - BLOCK_SIZE);
	localparam logic [CNT_W-1:0] OUT_BLOCK = CNT_W'(BLOCK_SIZE);

	always_ff @(posedge okClk) begin
		if (rst) begin
			pipe_in_ready  <= 1'b0;
			pipe_out_ready <= 1'b0;
		end else begin
			pipe_in_ready  <= (in_count <= IN_LIMIT);    // whole block still fits
			pipe_out_ready <= (out_count >= OUT_BLOCK);  // a full block waiting
		end
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tb_accel_host_top -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "Everything OK" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

/* sources.f */
accel_pkg.sv
sync_fifo.sv
pipe_throttle.sv
stream_mover.sv
dest_router.sv
csb.sv
accel_host_top.sv
tb_accel_host_top.sv

/* stream_mover.sv */
`timescale 1ns/1ps
`default_nettype none

module stream_mover import accel_pkg::*; #(
	parameter int FIFO_DEPTH = 64,
	parameter int CNT_W = 7
) (
	input  logic             okClk,
	input  logic             rst,
	input  logic             move_en,
	input  word_t            src_data,
	input  logic             src_empty,
	input  logic [CNT_W-1:0] dest_count,
	output logic             src_rd,
	output logic             mv_we,
	output word_t            mv_data
);

	// one slot kept free for the word already in flight
	localparam logic [CNT_W-1:0] ROOM_LIMIT = CNT_W'(FIFO_DEPTH - 2);

	logic dest_room;

	assign dest_room = (dest_count <= ROOM_LIMIT);
	assign src_rd    = move_en & ~src_empty & dest_room;

	// ----------------------------------------------------------------------
	// holding register written one cycle after the pop
	// ----------------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (rst) begin
			mv_we <= 1'b0;
		end else begin
			mv_we <= src_rd;  // one strobe per popped word
		end
	end

	always_ff @(posedge okClk) begin
		if (src_rd) begin
			mv_data <= src_data;  // head of show-ahead fifo
		end
	end

endmodule

`default_nettype wire

/* sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
	parameter type payload_t = logic [31:0],
	parameter int  FIFO_DEPTH = 64,
	parameter int  CNT_W = 7
) (
	input  logic             okClk,
	input  logic             rst,
	input  logic             clear,
	input  logic             wr,
	input  payload_t         din,
	input  logic             rd,
	output payload_t         dout,
	output logic             empty,
	output logic             full,
	output logic [CNT_W-1:0] count
);

	localparam int AW = $clog2(FIFO_DEPTH);

	payload_t       mem [FIFO_DEPTH];  // register array
	logic [AW-1:0]  wr_ptr;
	logic [AW-1:0]  rd_ptr;
	logic           wr_ok;
	logic           rd_ok;

	assign wr_ok = wr & ~full;
	assign rd_ok = rd & ~empty;

	assign empty = (count == '0);
	assign full  = (count == CNT_W'(FIFO_DEPTH));
	assign dout  = mem[rd_ptr];  // show-ahead head

	always_ff @(posedge okClk) begin
		if (wr_ok) begin
			mem[wr_ptr] <= din;
		end
	end

	// ----------------------------------------------------------------------
	// pointers and occupancy
	// ----------------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (rst || clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_ok) begin
				wr_ptr <= wr_ptr + 1'b1;  // wraps at the power-of-two depth
			end
			if (rd_ok) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wr_ok, rd_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// producers and consumers live in other modules
	a_no_write_full: assert property (@(posedge okClk) disable iff (rst || clear)
		!(wr && full));
	a_no_read_empty: assert property (@(posedge okClk) disable iff (rst || clear)
		!(rd && empty));

endmodule

`default_nettype wire

/* tb_accel_host_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_accel_host_top import accel_pkg::*; ();

	localparam int FIFO_DEPTH = 64;
	localparam int BLOCK_SIZE = 8;
	localparam int BUFFER_HEADROOM = 4;
	localparam int TMO = 2000;  // cycles per wait loop

	localparam int W_IN_READY = 0;
	localparam int W_OUT_READY = 1;
	localparam int W_RUN = 2;
	localparam int W_DATA = 3;
	localparam int W_IRQ = 4;

	logic       okClk;
	logic       rst;
	ctrl_t      ctrl;
	logic       pipe_in_write;
	word_t      pipe_in_data;
	logic       pipe_in_ready;
	logic       pipe_out_read;
	word_t      pipe_out_data;
	logic       pipe_out_empty;
	logic       pipe_out_ready;
	logic       data_rd;
	feat_pair_t data_out;
	logic       data_empty;
	op_status_t status;
	logic       irq;

	integer     seed;
	word_t      tx_q[$];      // words still to send
	word_t      exp_out[$];   // expected pipe-out words
	feat_pair_t exp_data[$];  // expected data pairs
	int         exp_irq;
	int         irq_count;
	logic       model_run;
	logic [15:0] model_left;
	op_status_t exp_stat;

	accel_host_top #(
		.FIFO_DEPTH      (FIFO_DEPTH),
		.BLOCK_SIZE      (BLOCK_SIZE),
		.BUFFER_HEADROOM (BUFFER_HEADROOM)
	) dut_i (
		.okClk          (okClk),
		.rst            (rst),
		.ctrl           (ctrl),
		.pipe_in_write  (pipe_in_write),
		.pipe_in_data   (pipe_in_data),
		.pipe_in_ready  (pipe_in_ready),
		.pipe_out_read  (pipe_out_read),
		.pipe_out_data  (pipe_out_data),
		.pipe_out_empty (pipe_out_empty),
		.pipe_out_ready (pipe_out_ready),
		.data_rd        (data_rd),
		.data_out       (data_out),
		.data_empty     (data_empty),
		.status         (status),
		.irq            (irq));

	initial begin
		okClk = 1'b0;
		forever #5 okClk = ~okClk;
	end

	always @(negedge okClk) begin
		if (rst) begin
			irq_count <= 0;
		end else if (irq) begin
			irq_count <= irq_count + 1;  // pulse is one cycle wide
		end
	end

	// ----------------------------------------------------------------------
	// checks
	// ----------------------------------------------------------------------
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			abort_run($sformatf("FAIL %s: got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_pair(input string name, input feat_pair_t got, input feat_pair_t exp);
		if (got !== exp) begin
			abort_run($sformatf("FAIL %s: got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_status(input string name, input op_status_t got,
		input op_status_t exp);
		if (got !== exp) begin
			abort_run($sformatf("FAIL %s: got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			abort_run($sformatf("FAIL %s: got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_irqs();
		if (irq_count != exp_irq) begin
			abort_run($sformatf("FAIL irq_count: got %h expected %h", irq_count, exp_irq));
		end
	endtask

	// ----------------------------------------------------------------------
	// reference model applying the router rule to each sent word
	// ----------------------------------------------------------------------
	task automatic model_word(input word_t w);
		cmd_t       c;
		feat_pair_t p;
		c = w;
		p.hi = w[31:16];
		p.lo = w[15:0];
		if (!ctrl.op_en) begin
			exp_out.push_back(w);
		end else if (!model_run) begin
			exp_stat.op_type = c.op_type;
			exp_stat.op_num  = c.op_num;
			exp_stat.op_run  = (c.op_num != 16'd0);
			model_run        = (c.op_num != 16'd0);
			model_left       = c.op_num;
			if (c.op_num == 16'd0) begin
				exp_irq++;  // empty op
			end
		end else begin
			exp_data.push_back(p);
			model_left = model_left - 16'd1;
			if (model_left == 16'd0) begin
				model_run       = 1'b0;
				exp_stat.op_run = 1'b0;
				exp_irq++;
			end
		end
	endtask

	task automatic queue_cmd(input logic [15:0] num);
		cmd_t c;
		int   r;
		r = $random(seed);
		c.op_type  = op_type_e'({1'b0, r[1:0]});
		c.reserved = r[14:2];
		c.op_num   = num;
		tx_q.push_back(c);
	endtask

	task automatic queue_data(input int n);
		for (int i = 0; i < n; i++) begin
			tx_q.push_back($random(seed));
		end
	endtask

	// ----------------------------------------------------------------------
	// stimulus and waits
	// ----------------------------------------------------------------------
	function automatic logic level_of(input int which);
		case (which)
			W_IN_READY:  return pipe_in_ready;
			W_OUT_READY: return pipe_out_ready;
			W_RUN:       return status.op_run;
			W_DATA:      return !data_empty;
			default:     return (irq_count == exp_irq);
		endcase
	endfunction

	task automatic wait_level(input string name, input int which, input logic level);
		int t;
		t = 0;
		while (level_of(which) !== level) begin
			@(negedge okClk);
			t++;
			if (t > TMO) begin
				abort_run($sformatf("timeout waiting for %s to become %0d", name, level));
			end
		end
	endtask

	task automatic settle(input int n);
		repeat (n) @(negedge okClk);
	endtask

	task automatic flush_tx(input bit gated);
		int n;
		while (tx_q.size() > 0) begin
			if (gated) begin
				wait_level("pipe_in_ready", W_IN_READY, 1'b1);
			end
			n = 0;
			while (tx_q.size() > 0 && n < BLOCK_SIZE) begin
				@(negedge okClk);
				pipe_in_write = 1'b1;
				pipe_in_data  = tx_q[0];
				model_word(tx_q.pop_front());
				n++;
			end
			@(negedge okClk);
			pipe_in_write = 1'b0;
		end
	endtask

	task automatic drain_out();
		int t;
		t = 0;
		while (exp_out.size() > 0) begin
			@(negedge okClk);
			pipe_out_read = 1'b0;
			if (!pipe_out_empty) begin
				check_word("pipe_out_data", pipe_out_data, exp_out.pop_front());
				pipe_out_read = 1'b1;  // head advances at next edge
				t = 0;
			end else begin
				t++;
				if (t > TMO) begin
					abort_run("timeout waiting for a word at pipe-out");
				end
			end
		end
		@(negedge okClk);
		pipe_out_read = 1'b0;
	endtask

	task automatic drain_data();
		int t;
		t = 0;
		while (exp_data.size() > 0) begin
			@(negedge okClk);
			data_rd = 1'b0;
			if (!data_empty) begin
				check_pair("data_out", data_out, exp_data.pop_front());
				data_rd = 1'b1;
				t = 0;
			end else begin
				t++;
				if (t > TMO) begin
					abort_run("timeout waiting for a pair at the data FIFO");
				end
			end
		end
		@(negedge okClk);
		data_rd = 1'b0;
	endtask

	// ----------------------------------------------------------------------
	// test sequence
	// ----------------------------------------------------------------------
	initial begin
		int num;
		seed          = 32'hb265;
		rst           = 1'b1;
		ctrl          = '0;
		pipe_in_write = 1'b0;
		pipe_in_data  = '0;
		pipe_out_read = 1'b0;
		data_rd       = 1'b0;
		exp_irq       = 0;
		model_run     = 1'b0;
		model_left    = '0;
		exp_stat      = '0;
		repeat (2) @(posedge okClk);
		@(negedge okClk);
		check_flag("pipe_in_ready", pipe_in_ready, 1'b0);  // reset values
		check_flag("pipe_out_ready", pipe_out_ready, 1'b0);
		check_flag("irq", irq, 1'b0);
		check_flag("pipe_out_empty", pipe_out_empty, 1'b1);
		check_flag("data_empty", data_empty, 1'b1);
		check_status("status", status, exp_stat);
		rst = 1'b0;
		ctrl.move_en = 1'b1;

		// pass-through with op_en low
		queue_data(4 * BLOCK_SIZE);
		flush_tx(1'b1);
		drain_out();
		settle(4);
		check_flag("pipe_out_empty", pipe_out_empty, 1'b1);

		// single command then its data
		ctrl.op_en = 1'b1;
		num = ($random(seed) & 32'h7fff_ffff) % 20 + 1;
		queue_cmd(16'(num));
		flush_tx(1'b1);
		wait_level("op_run", W_RUN, 1'b1);
		check_status("status", status, exp_stat);
		queue_data(num);
		flush_tx(1'b1);
		drain_data();
		wait_level("irq count", W_IRQ, 1'b1);
		settle(4);
		check_irqs();
		check_status("status", status, exp_stat);
		check_flag("pipe_out_empty", pipe_out_empty, 1'b1);

		// stream of commands including one with no data
		for (int k = 0; k < 4; k++) begin
			num = (k == 2) ? 0 : ($random(seed) & 32'h7fff_ffff) % 12 + 1;
			queue_cmd(16'(num));
			queue_data(num);
		end
		flush_tx(1'b1);
		drain_data();
		wait_level("irq count", W_IRQ, 1'b1);
		settle(4);
		check_irqs();
		check_status("status", status, exp_stat);
		check_flag("pipe_out_empty", pipe_out_empty, 1'b1);

		// throttle levels
		ctrl.move_en = 1'b0;
		ctrl.op_en   = 1'b0;
		queue_data(FIFO_DEPTH - BUFFER_HEADROOM - BLOCK_SIZE);
		flush_tx(1'b0);
		settle(3);
		check_flag("pipe_in_ready", pipe_in_ready, 1'b1);  // at the limit
		queue_data(4);
		flush_tx(1'b0);
		wait_level("pipe_in_ready", W_IN_READY, 1'b0);
		check_flag("pipe_out_ready", pipe_out_ready, 1'b0);
		ctrl.move_en = 1'b1;
		wait_level("pipe_out_ready", W_OUT_READY, 1'b1);
		drain_out();
		wait_level("pipe_in_ready", W_IN_READY, 1'b1);
		settle(4);
		check_flag("pipe_out_ready", pipe_out_ready, 1'b0);

		// clear with words parked in both output FIFOs
		queue_data(BLOCK_SIZE);
		flush_tx(1'b1);
		wait_level("pipe_out_ready", W_OUT_READY, 1'b1);
		ctrl.op_en = 1'b1;
		queue_cmd(16'd10);
		queue_data(3);
		flush_tx(1'b1);
		wait_level("data FIFO not empty", W_DATA, 1'b1);
		settle(8);
		check_flag("op_run", status.op_run, 1'b1);
		ctrl.pipe_clear = 1'b1;
		ctrl.csb_clear  = 1'b1;
		@(negedge okClk);
		ctrl.pipe_clear = 1'b0;
		ctrl.csb_clear  = 1'b0;
		exp_out.delete();
		exp_data.delete();
		model_run = 1'b0;
		check_flag("pipe_out_empty", pipe_out_empty, 1'b1);
		check_flag("data_empty", data_empty, 1'b1);
		check_flag("op_run", status.op_run, 1'b0);

		settle(4);
		if (exp_out.size() != 0 || exp_data.size() != 0 || irq_count != exp_irq) begin
			abort_run("expected words or irq pulses were left over at the end");
		end else begin
			$display("Everything OK");
			$finish;
		end
	end

endmodule

`default_nettype wire
